//--- hdl/n64_cfg_pkg.sv
package n64_cfg_pkg;

    // register index comes from address bits 3 to 1 of the host bus
    typedef enum logic [2:0] {
        REG_STATUS    = 3'd0,
        REG_COMMAND   = 3'd1,
        REG_DATA_0_H  = 3'd2,
        REG_DATA_0_L  = 3'd3,
        REG_DATA_1_H  = 3'd4,
        REG_DATA_1_L  = 3'd5,
        REG_VERSION_H = 3'd6,
        REG_VERSION_L = 3'd7
    } e_reg;

    // command code sits in bits 6 to 0 of the command byte
    typedef enum logic [6:0] {
        CMD_GET       = 7'd0,
        CMD_SET       = 7'd1,
        CMD_RESET_ALL = 7'd2
    } e_cmd;

    // bit 7 of the command byte asks for an interrupt on completion
    localparam int CMD_IRQ_BIT = 7;

    typedef enum logic [2:0] {
        SETTING_BOOT_MODE = 3'd0,
        SETTING_SAVE_TYPE = 3'd1,
        SETTING_ROM_WRITE = 3'd2,
        SETTING_CIC_SEED  = 3'd3,
        SETTING_TV_TYPE   = 3'd4
    } e_setting;

    // reported in result0 by RESET_ALL
    localparam logic [31:0] CFG_NUM_SETTINGS = 32'd5;

    // upper bounds of the settings with a restricted range
    localparam logic [2:0] SAVE_TYPE_MAX = 3'd5;
    localparam logic [1:0] TV_TYPE_MAX = 2'd2;

    localparam logic [1:0] CFG_DEFAULT_BOOT_MODE = 2'd0;
    localparam logic [2:0] CFG_DEFAULT_SAVE_TYPE = 3'd0;
    localparam logic CFG_DEFAULT_ROM_WRITE = 1'b0;
    localparam logic [7:0] CFG_DEFAULT_CIC_SEED = 8'h3F;
    localparam logic [1:0] CFG_DEFAULT_TV_TYPE = 2'd1;

    typedef struct packed {
        logic [3:0] address;
        logic write;
        logic [15:0] wdata;
    } reg_bus_req_t;

    typedef struct packed {
        logic [7:0] cmd;
        logic [31:0] arg0;
        logic [31:0] arg1;
    } cfg_req_t;

    typedef struct packed {
        logic done;
        logic error;
        logic irq;
        logic [31:0] result0;
        logic [31:0] result1;
    } cfg_rsp_t;

    typedef struct packed {
        logic read;
        logic write;
        logic restore;
        logic [2:0] id;
        logic [7:0] value;
    } setting_access_t;

endpackage

//--- hdl/n64_cfg_settings.sv
`timescale 1ns/100ps

module n64_cfg_settings (
    input logic clk,
    input logic reset,

    input n64_cfg_pkg::setting_access_t access,
    output logic [7:0] old_value,
    output logic id_ok,
    output logic value_ok
);

    logic [1:0] boot_mode;
    logic [2:0] save_type;
    logic rom_write;
    logic [7:0] cic_seed;
    logic [1:0] tv_type;

    logic [7:0] stored_value;
    logic apply_ok;

    // each setting is checked against its own width and range
    always_comb begin
        stored_value = 8'd0;
        id_ok = 1'b1;
        value_ok = 1'b0;
        case (access.id)
            n64_cfg_pkg::SETTING_BOOT_MODE: begin
                stored_value = {6'd0, boot_mode};
                value_ok = (access.value[7:2] == 6'd0);
            end
            n64_cfg_pkg::SETTING_SAVE_TYPE: begin
                stored_value = {5'd0, save_type};
                value_ok = (access.value <= {5'd0, n64_cfg_pkg::SAVE_TYPE_MAX});
            end
            n64_cfg_pkg::SETTING_ROM_WRITE: begin
                stored_value = {7'd0, rom_write};
                value_ok = (access.value[7:1] == 7'd0);
            end
            n64_cfg_pkg::SETTING_CIC_SEED: begin
                stored_value = cic_seed;
                value_ok = 1'b1;
            end
            n64_cfg_pkg::SETTING_TV_TYPE: begin
                stored_value = {6'd0, tv_type};
                value_ok = (access.value <= {6'd0, n64_cfg_pkg::TV_TYPE_MAX});
            end
            default: id_ok = 1'b0;
        endcase
    end

    assign old_value = (access.read || access.write) ? stored_value : 8'd0;
    assign apply_ok = id_ok && value_ok;

    always_ff @(posedge clk) begin
        if (reset || (access.restore && apply_ok)) begin
            boot_mode <= n64_cfg_pkg::CFG_DEFAULT_BOOT_MODE;
            save_type <= n64_cfg_pkg::CFG_DEFAULT_SAVE_TYPE;
            rom_write <= n64_cfg_pkg::CFG_DEFAULT_ROM_WRITE;
            cic_seed <= n64_cfg_pkg::CFG_DEFAULT_CIC_SEED;
            tv_type <= n64_cfg_pkg::CFG_DEFAULT_TV_TYPE;
        end else if (access.write && apply_ok) begin
            case (access.id)
                n64_cfg_pkg::SETTING_BOOT_MODE: boot_mode <= access.value[1:0];
                n64_cfg_pkg::SETTING_SAVE_TYPE: save_type <= access.value[2:0];
                n64_cfg_pkg::SETTING_ROM_WRITE: rom_write <= access.value[0];
                n64_cfg_pkg::SETTING_CIC_SEED: cic_seed <= access.value;
                n64_cfg_pkg::SETTING_TV_TYPE: tv_type <= access.value[1:0];
                default: begin
                end
            endcase
        end
    end

endmodule

//--- hdl/n64_cfg_exec.sv
`timescale 1ns/100ps

module n64_cfg_exec (
    input logic clk,
    input logic reset,

    input logic pending,
    input n64_cfg_pkg::cfg_req_t req,
    output n64_cfg_pkg::cfg_rsp_t rsp,

    output n64_cfg_pkg::setting_access_t access,
    input logic [7:0] old_value,
    input logic id_ok,
    input logic value_ok
);

    typedef enum logic {
        S_IDLE,
        S_EXEC
    } e_state;

    e_state state;

    n64_cfg_pkg::cfg_req_t req_q;
    n64_cfg_pkg::e_cmd cmd_code;
    logic [2:0] setting_id;
    logic [7:0] setting_value;
    logic access_ok;

    assign cmd_code = n64_cfg_pkg::e_cmd'(req_q.cmd[6:0]);
    assign setting_id = req_q.arg0[2:0];
    assign setting_value = req_q.arg1[7:0];
    assign access_ok = id_ok && value_ok;

    // one execute cycle per command, then back to idle as pending drops
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (pending) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && pending) begin
            req_q <= req;
        end
    end

    // the store answers in the same cycle, so done and results are combinational
    always_comb begin
        access = '0;
        rsp = '0;

        if (state == S_EXEC) begin
            rsp.done = 1'b1;
            rsp.irq = req_q.cmd[n64_cfg_pkg::CMD_IRQ_BIT];

            case (cmd_code)
                n64_cfg_pkg::CMD_GET: begin
                    access.read = 1'b1;
                    access.id = setting_id;
                    rsp.error = !id_ok;
                    rsp.result0 = {29'd0, setting_id};
                    rsp.result1 = {24'd0, old_value};
                end

                n64_cfg_pkg::CMD_SET: begin
                    access.read = 1'b1;
                    access.write = 1'b1;
                    access.id = setting_id;
                    access.value = setting_value;
                    rsp.error = !access_ok;
                    rsp.result0 = {29'd0, setting_id};
                    rsp.result1 = {24'd0, old_value};
                end

                n64_cfg_pkg::CMD_RESET_ALL: begin
                    // a legal id and value pair lets the store accept the restore
                    access.restore = 1'b1;
                    access.id = n64_cfg_pkg::SETTING_BOOT_MODE;
                    access.value = {6'd0, n64_cfg_pkg::CFG_DEFAULT_BOOT_MODE};
                    rsp.error = !access_ok;
                    rsp.result0 = n64_cfg_pkg::CFG_NUM_SETTINGS;
                    rsp.result1 = 32'd0;
                end

                default: begin
                    rsp.error = 1'b1;
                end
            endcase
        end
    end

endmodule

//--- hdl/n64_cfg.sv
`timescale 1ns/100ps

module n64_cfg #(
    parameter logic [31:0] CFG_VERSION = 32'h0000_0000
) (
    input logic clk,
    input logic reset,

    input n64_cfg_pkg::reg_bus_req_t reg_bus,
    output logic [15:0] rdata,
    output logic irq,

    output logic pending,
    output n64_cfg_pkg::cfg_req_t req,
    input n64_cfg_pkg::cfg_rsp_t rsp
);

    n64_cfg_pkg::e_reg reg_idx;

    logic error;
    logic [7:0] cmd;
    logic [31:0] arg0;
    logic [31:0] arg1;
    logic [31:0] result0;
    logic [31:0] result1;

    assign reg_idx = n64_cfg_pkg::e_reg'(reg_bus.address[3:1]);

    assign req.cmd = cmd;
    assign req.arg0 = arg0;
    assign req.arg1 = arg1;

    // the DATA registers read back results, never the arguments
    always_comb begin
        rdata = 16'd0;
        case (reg_idx)
            n64_cfg_pkg::REG_STATUS: rdata = {pending, error, 14'd0};
            n64_cfg_pkg::REG_DATA_0_H: rdata = result0[31:16];
            n64_cfg_pkg::REG_DATA_0_L: rdata = result0[15:0];
            n64_cfg_pkg::REG_DATA_1_H: rdata = result1[31:16];
            n64_cfg_pkg::REG_DATA_1_L: rdata = result1[15:0];
            n64_cfg_pkg::REG_VERSION_H: rdata = CFG_VERSION[31:16];
            n64_cfg_pkg::REG_VERSION_L: rdata = CFG_VERSION[15:0];
            default: rdata = 16'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            error <= 1'b0;
            irq <= 1'b0;
            cmd <= 8'h00;
            arg0 <= 32'd0;
            arg1 <= 32'd0;
            result0 <= 32'd0;
            result1 <= 32'd0;
        end else begin
            if (rsp.done) begin
                pending <= 1'b0;
                error <= rsp.error;
                result0 <= rsp.result0;
                result1 <= rsp.result1;
                if (rsp.irq) begin
                    irq <= 1'b1;
                end
            end

            // placed after the done handling so an irq clear wins over a set
            if (reg_bus.write) begin
                case (reg_idx)
                    n64_cfg_pkg::REG_COMMAND: begin
                        // a command written while one is in flight is dropped
                        if (!pending) begin
                            pending <= 1'b1;
                            error <= 1'b0;
                            cmd <= reg_bus.wdata[7:0];
                        end
                    end
                    n64_cfg_pkg::REG_DATA_0_H: arg0[31:16] <= reg_bus.wdata;
                    n64_cfg_pkg::REG_DATA_0_L: arg0[15:0] <= reg_bus.wdata;
                    n64_cfg_pkg::REG_DATA_1_H: arg1[31:16] <= reg_bus.wdata;
                    n64_cfg_pkg::REG_DATA_1_L: arg1[15:0] <= reg_bus.wdata;
                    n64_cfg_pkg::REG_VERSION_L: irq <= 1'b0;
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- hdl/n64_cfg_top.sv
`timescale 1ns/100ps

module n64_cfg_top #(
    parameter logic [31:0] CFG_VERSION = 32'h4E36_4301
) (
    input logic clk,
    input logic reset,

    input n64_cfg_pkg::reg_bus_req_t reg_bus,
    output logic [15:0] rdata,
    output logic irq
);

    logic pending;
    n64_cfg_pkg::cfg_req_t req;
    n64_cfg_pkg::cfg_rsp_t rsp;

    n64_cfg_pkg::setting_access_t access;
    logic [7:0] old_value;
    logic id_ok;
    logic value_ok;

    // host registers, pending state and result latches
    n64_cfg #(
        .CFG_VERSION(CFG_VERSION)
    ) n64_cfg_inst (
        .clk(clk),
        .reset(reset),
        .reg_bus(reg_bus),
        .rdata(rdata),
        .irq(irq),
        .pending(pending),
        .req(req),
        .rsp(rsp)
    );

    n64_cfg_exec n64_cfg_exec_inst (
        .clk(clk),
        .reset(reset),
        .pending(pending),
        .req(req),
        .rsp(rsp),
        .access(access),
        .old_value(old_value),
        .id_ok(id_ok),
        .value_ok(value_ok)
    );

    n64_cfg_settings n64_cfg_settings_inst (
        .clk(clk),
        .reset(reset),
        .access(access),
        .old_value(old_value),
        .id_ok(id_ok),
        .value_ok(value_ok)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset is released on a rising edge, like any other synchronous input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- tb/n64_cfg_tb.sv
`timescale 1ns/100ps

module n64_cfg_tb;

    localparam logic [31:0] CFG_VERSION = 32'h4E36_4301;
    localparam int WORDS_PER_VECTOR = 7;
    localparam int MAX_VECTORS = 64;
    localparam int RESET_TIMEOUT = 20;
    localparam int CMD_TIMEOUT = 16;
    localparam int CMD_LATENCY = 2;

    logic clk;
    logic reset;
    n64_cfg_pkg::reg_bus_req_t reg_bus;
    logic [15:0] rdata;
    logic irq;

    logic [31:0] vectors [0:MAX_VECTORS * WORDS_PER_VECTOR - 1];
    logic [31:0] rng_state;
    logic [15:0] got;
    int num_vectors;
    int base;
    int cycles;

    tb_clock_gen #(
        .PERIOD(40),
        .RESET_CYCLES(5)
    ) clock_gen0 (
        .clk(clk),
        .reset(reset)
    );

    n64_cfg_top dut0 (
        .clk(clk),
        .reset(reset),
        .reg_bus(reg_bus),
        .rdata(rdata),
        .irq(irq)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_rdata(input string name, input logic [15:0] value,
                               input logic [15:0] expected);
        if (value !== expected) begin
            report_failure($sformatf("[ERROR] %0t %s got %04h expected %04h",
                                     $time, name, value, expected));
        end
    endtask

    task automatic check_status(input logic [15:0] value, input logic exp_pending,
                                input logic exp_error);
        if (value[15] !== exp_pending) begin
            report_failure($sformatf("[ERROR] %0t STATUS.pending got %0b expected %0b",
                                     $time, value[15], exp_pending));
        end
        if (value[14] !== exp_error) begin
            report_failure($sformatf("[ERROR] %0t STATUS.error got %0b expected %0b",
                                     $time, value[14], exp_error));
        end
    endtask

    task automatic check_irq(input logic value, input logic expected);
        if (value !== expected) begin
            report_failure($sformatf("[ERROR] %0t irq got %0b expected %0b",
                                     $time, value, expected));
        end
    endtask

    // 0 to 3 idle cycles before each bus access
    task automatic idle_gap();
        rng_state = xorshift32(rng_state);
        repeat (rng_state[1:0]) @(posedge clk);
    endtask

    // returns right after the edge at which the DUT takes the write
    task automatic write_reg(input n64_cfg_pkg::e_reg idx, input logic [15:0] data);
        idle_gap();
        @(posedge clk);
        reg_bus.address <= {idx, 1'b0};
        reg_bus.write <= 1'b1;
        reg_bus.wdata <= data;
        @(posedge clk);
        reg_bus.write <= 1'b0;
    endtask

    task automatic read_reg(input n64_cfg_pkg::e_reg idx, output logic [15:0] data);
        idle_gap();
        @(posedge clk);
        reg_bus.address <= {idx, 1'b0};
        reg_bus.write <= 1'b0;
        @(negedge clk);
        data = rdata;
    endtask

    task automatic run_command(input logic [7:0] cmd, input logic [31:0] arg0,
                               input logic [31:0] arg1, input logic exp_error,
                               input logic exp_irq);
        write_reg(n64_cfg_pkg::REG_DATA_0_H, arg0[31:16]);
        write_reg(n64_cfg_pkg::REG_DATA_0_L, arg0[15:0]);
        write_reg(n64_cfg_pkg::REG_DATA_1_H, arg1[31:16]);
        write_reg(n64_cfg_pkg::REG_DATA_1_L, arg1[15:0]);
        write_reg(n64_cfg_pkg::REG_COMMAND, {8'h00, cmd});
        // poll STATUS from the cycle right after the command write
        reg_bus.address <= {n64_cfg_pkg::REG_STATUS, 1'b0};
        cycles = 0;
        @(negedge clk);
        check_status(rdata, 1'b1, 1'b0);
        check_irq(irq, 1'b0);
        while (rdata[15]) begin
            @(posedge clk);
            cycles++;
            if (cycles > CMD_TIMEOUT) begin
                report_failure("the command was still pending when the poll timed out");
            end
            @(negedge clk);
            if (rdata[15]) begin
                check_irq(irq, 1'b0);
            end
        end
        if (cycles != CMD_LATENCY) begin
            report_failure($sformatf("pending fell %0d cycles after the command write, not %0d",
                                     cycles, CMD_LATENCY));
        end
        check_status(rdata, 1'b0, exp_error);
        check_irq(irq, exp_irq);
    endtask

    initial begin
        reg_bus = '0;
        rng_state = 32'd57997;

        $readmemh("tb/cfg_vectors.txt", vectors);
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS &&
               !$isunknown(vectors[num_vectors * WORDS_PER_VECTOR])) begin
            num_vectors++;
        end
        if (num_vectors == 0) begin
            report_failure("no vectors could be read from tb/cfg_vectors.txt");
        end

        cycles = 0;
        while (reset !== 1'b0) begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                report_failure("reset was never released");
            end
        end

        read_reg(n64_cfg_pkg::REG_STATUS, got);
        check_rdata("STATUS", got, 16'h0000);
        check_irq(irq, 1'b0);
        read_reg(n64_cfg_pkg::REG_VERSION_H, got);
        check_rdata("VERSION_H", got, CFG_VERSION[31:16]);
        read_reg(n64_cfg_pkg::REG_VERSION_L, got);
        check_rdata("VERSION_L", got, CFG_VERSION[15:0]);

        for (int i = 0; i < num_vectors; i++) begin
            base = i * WORDS_PER_VECTOR;
            run_command(vectors[base][7:0], vectors[base + 1], vectors[base + 2],
                        vectors[base + 3][0], vectors[base + 6][0]);
            read_reg(n64_cfg_pkg::REG_DATA_0_H, got);
            check_rdata("DATA_0_H", got, vectors[base + 4][31:16]);
            read_reg(n64_cfg_pkg::REG_DATA_0_L, got);
            check_rdata("DATA_0_L", got, vectors[base + 4][15:0]);
            read_reg(n64_cfg_pkg::REG_DATA_1_H, got);
            check_rdata("DATA_1_H", got, vectors[base + 5][31:16]);
            read_reg(n64_cfg_pkg::REG_DATA_1_L, got);
            check_rdata("DATA_1_L", got, vectors[base + 5][15:0]);
            // irq holds across the result reads until VERSION_L is written
            check_irq(irq, vectors[base + 6][0]);
            if (vectors[base + 6][0]) begin
                write_reg(n64_cfg_pkg::REG_VERSION_L, 16'h0000);
                @(negedge clk);
                check_irq(irq, 1'b0);
            end
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- tb/cfg_vectors.txt
// columns in hex: cmd arg0 arg1 error result0 result1 irq
// ids 0 to 4 are boot mode, save type, rom write, cic seed and tv type
00 00000000 00000000 0 00000000 00000000 0
00 00000001 00000000 0 00000001 00000000 0
00 00000002 00000000 0 00000002 00000000 0
80 00000003 00000000 0 00000003 0000003F 1
00 00000004 00000000 0 00000004 00000001 0
// legal sets, each one read back
01 00000000 00000002 0 00000000 00000000 0
00 00000000 00000000 0 00000000 00000002 0
01 00000001 00000005 0 00000001 00000000 0
00 00000001 00000000 0 00000001 00000005 0
81 00000002 00000001 0 00000002 00000000 1
00 00000002 00000000 0 00000002 00000001 0
01 00000003 000000A5 0 00000003 0000003F 0
00 00000003 00000000 0 00000003 000000A5 0
01 00000004 00000002 0 00000004 00000001 0
00 00000004 00000000 0 00000004 00000002 0
// rejected values, ids and codes leave the store as it was
01 00000001 00000006 1 00000001 00000005 0
00 00000001 00000000 0 00000001 00000005 0
81 00000004 00000003 1 00000004 00000002 1
00 00000004 00000000 0 00000004 00000002 0
01 00000005 00000001 1 00000005 00000000 0
01 00000006 00000001 1 00000006 00000000 0
00 00000007 00000000 1 00000007 00000000 0
7F 00000000 00000000 1 00000000 00000000 0
83 00000000 00000000 1 00000000 00000000 1
// restore all defaults and read them back
82 00000000 00000000 0 00000005 00000000 1
00 00000000 00000000 0 00000000 00000000 0
00 00000001 00000000 0 00000001 00000000 0
00 00000002 00000000 0 00000002 00000000 0
00 00000003 00000000 0 00000003 0000003F 0
00 00000004 00000000 0 00000004 00000001 0

//--- files.f
hdl/n64_cfg_pkg.sv
hdl/n64_cfg_settings.sv
hdl/n64_cfg_exec.sv
hdl/n64_cfg.sv
hdl/n64_cfg_top.sv
tb/tb_clock_gen.sv
tb/n64_cfg_tb.sv

//--- Bender.yml
package:
  name: n64_cfg

sources:
  - hdl/n64_cfg_pkg.sv
  - hdl/n64_cfg_settings.sv
  - hdl/n64_cfg_exec.sv
  - hdl/n64_cfg.sv
  - hdl/n64_cfg_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/n64_cfg_tb.sv
